// File: common/producer_pkg.sv
`default_nettype none

package producer_pkg;

    // **************************************************
    // sizes of the adc data path
    // **************************************************
    localparam int ADC_CHANNELS      = 8;   // channels per sample period
    localparam int ADC_BANK_CHANNELS = 4;   // A bank and B bank, 4 each
    localparam int SAMPLE_W          = 18;  // raw adc sample
    localparam int LANE_W            = 32;  // one sample + pad + counter byte
    localparam int STREAM_W          = 128; // four lanes per stream word
    localparam int PHASE_W           = 6;   // external phase count, 0..24

    localparam int FIFO_DEPTH        = 32;  // words
    localparam int FIFO_ADDR_W       = 5;
    localparam int FIFO_ALMOST_FULL  = 28;  // fill level for the status flag

    localparam int PKT_WORDS         = 16;  // last on every 16th written word
    localparam int CREDIT_INIT       = 4;   // receiver buffer size in words
    localparam int CREDIT_W          = 3;

    // phase events inside one sample period
    localparam int PHASE_LO_WORD     = 1;
    localparam int PHASE_HI_WORD     = 2;
    localparam int PHASE_COUNT_STEP  = 3;

    // **************************************************
    // types
    // **************************************************
    typedef logic [SAMPLE_W-1:0]               adc_sample_t;
    typedef adc_sample_t [ADC_BANK_CHANNELS-1:0] adc_bank_t;  // 72 bits
    typedef logic [63:0]                       sample_count_t;
    typedef logic [STREAM_W-1:0]               stream_word_t;
    typedef logic [FIFO_ADDR_W:0]              fifo_level_t;  // 0..FIFO_DEPTH
    typedef logic [CREDIT_W-1:0]               credit_t;

    typedef struct packed {
        logic         valid;
        logic         is_high;  // second word of the sample pair
        stream_word_t data;
    } framed_word_t;

    typedef struct packed {
        stream_word_t data;
        logic         last;     // packet end
    } fifo_entry_t;

    typedef struct packed {
        logic almost_full;
        logic fifo_empty;
        logic sample_dropped;   // sticky until acq_on drops
    } producer_status_t;

    typedef enum logic [1:0] {
        IDLE,
        HOLD_LO,   // low word on frame
        HOLD_HI    // high word on frame
    } framer_state_t;

endpackage

`default_nettype wire

// File: design/adc_sample_framer.sv
`timescale 1ns/1ps
`default_nettype none

module adc_sample_framer import producer_pkg::*; (
    input  logic               adc_data_clk,
    input  logic               acq_on,
    input  logic [PHASE_W-1:0] adc_phase,   // 0..24, wraps
    input  adc_bank_t          adc_a_bank,
    input  adc_bank_t          adc_b_bank,
    output framed_word_t       frame
);

    framer_state_t state;
    sample_count_t sample_cnt;     // counts every period, admitted or not
    stream_word_t  frame_data;
    stream_word_t  lo_word, hi_word;
    adc_sample_t   chan [ADC_CHANNELS];

    // **************************************************
    // lane packing
    // **************************************************
    always_comb begin
        for (int k = 0; k < ADC_BANK_CHANNELS; k++) begin
            chan[2*k]     = adc_a_bank[k];   // even channels from bank A
            chan[2*k + 1] = adc_b_bank[k];   // odd channels from bank B
        end
        // sample on top, six zero pad bits, counter byte at the bottom
        for (int n = 0; n < ADC_BANK_CHANNELS; n++) begin
            lo_word[LANE_W*n +: LANE_W] = {chan[n], {(LANE_W-SAMPLE_W-8){1'b0}},
                                           sample_cnt[8*n +: 8]};
            hi_word[LANE_W*n +: LANE_W] = {chan[n + ADC_BANK_CHANNELS],
                                           {(LANE_W-SAMPLE_W-8){1'b0}},
                                           sample_cnt[32 + 8*n +: 8]};
        end
    end

    // **************************************************
    // phase tracking
    // **************************************************
    always_ff @(posedge adc_data_clk or negedge acq_on) begin
        if (!acq_on) begin
            state <= IDLE;
        end else if (state == HOLD_LO) begin
            state <= HOLD_HI;        // high word always follows, one cycle later
        end else if (adc_phase == PHASE_W'(PHASE_LO_WORD)) begin
            state <= HOLD_LO;
        end else begin
            state <= IDLE;
        end
    end

    // word payload, loaded with the state change
    always_ff @(posedge adc_data_clk) begin
        if (state == HOLD_LO)
            frame_data <= hi_word;   // normally seen at PHASE_HI_WORD
        else if (adc_phase == PHASE_W'(PHASE_LO_WORD))
            frame_data <= lo_word;
    end

    // counter steps after both words have taken its value
    always_ff @(posedge adc_data_clk or negedge acq_on) begin
        if (!acq_on)
            sample_cnt <= '0;
        else if (adc_phase == PHASE_W'(PHASE_COUNT_STEP))
            sample_cnt <= sample_cnt + 64'd1;
    end

    assign frame = '{valid:   state != IDLE,
                     is_high: state == HOLD_HI,
                     data:    frame_data};

    // packer relies on strict lo/hi pairing for its admission decision
    // high word is taken while the phase count shows PHASE_HI_WORD
    a_hi_follows_lo: assert property (@(posedge adc_data_clk) disable iff (!acq_on)
        frame.valid && !frame.is_high |-> adc_phase == PHASE_W'(PHASE_HI_WORD)
                                          ##1 frame.valid && frame.is_high);

endmodule

`default_nettype wire

// File: design/word_packer.sv
`timescale 1ns/1ps
`default_nettype none

module word_packer import producer_pkg::*; (
    input  logic         adc_data_clk,
    input  logic         acq_on,
    input  logic         big_endian,
    input  framed_word_t frame,
    input  fifo_level_t  free_words,
    output logic         wr_en,
    output fifo_entry_t  wr_entry,
    output logic         sample_dropped
);

    logic lo_arrive;                          // first word of a pair on frame
    logic word_admit, word_swap;
    logic pair_admit, pair_swap;              // decision held for the high word
    logic [$clog2(PKT_WORDS)-1:0] wr_index;   // written words mod PKT_WORDS

    // reverse the four bytes inside every 32 bit lane
    function automatic stream_word_t swap_lanes(input stream_word_t w);
        stream_word_t s;
        for (int l = 0; l < STREAM_W/LANE_W; l++) begin
            for (int b = 0; b < LANE_W/8; b++)
                s[l*LANE_W + b*8 +: 8] = w[l*LANE_W + (LANE_W/8 - 1 - b)*8 +: 8];
        end
        return s;
    endfunction

    // **************************************************
    // admission per sample pair
    // **************************************************
    always_comb begin
        lo_arrive = frame.valid && !frame.is_high;
        if (lo_arrive) begin
            word_admit = free_words >= fifo_level_t'(2);   // room for both words
            word_swap  = big_endian;
        end else begin
            word_admit = frame.valid && pair_admit;
            word_swap  = pair_swap;
        end
    end

    always_ff @(posedge adc_data_clk or negedge acq_on) begin
        if (!acq_on) begin
            pair_admit     <= 1'b0;
            pair_swap      <= 1'b0;
            wr_en          <= 1'b0;
            wr_index       <= '0;
            sample_dropped <= 1'b0;
        end else begin
            wr_en <= word_admit;             // one cycle through the packer
            if (lo_arrive) begin
                pair_admit <= word_admit;
                pair_swap  <= big_endian;    // endian held for the pair
                if (!word_admit)
                    sample_dropped <= 1'b1;  // sticky
            end
            if (word_admit)
                wr_index <= wr_index + 1'b1;
        end
    end

    // payload, only looked at with wr_en
    always_ff @(posedge adc_data_clk) begin
        if (word_admit) begin
            wr_entry.data <= word_swap ? swap_lanes(frame.data) : frame.data;
            wr_entry.last <= int'(wr_index) == PKT_WORDS - 1;   // packet end
        end
    end

    // admission must have left room for the second word too
    a_no_write_without_room: assert property (@(posedge adc_data_clk) disable iff (!acq_on)
        wr_en |-> free_words != '0);

endmodule

`default_nettype wire

// File: stream_out/sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sample_fifo import producer_pkg::*; (
    input  logic        adc_data_clk,
    input  logic        acq_on,
    input  logic        wr_en,
    input  fifo_entry_t wr_entry,
    input  logic        rd_en,
    output fifo_entry_t rd_entry,      // head entry, show-ahead
    output logic        not_empty,
    output fifo_level_t free_words,
    output logic        almost_full
);

    fifo_entry_t             mem [FIFO_DEPTH];
    logic [FIFO_ADDR_W-1:0]  wr_ptr, rd_ptr;
    fifo_level_t             fill;         // words held
    logic                    full;
    logic                    do_push, do_pop;

    assign full    = fill == fifo_level_t'(FIFO_DEPTH);
    assign do_push = wr_en && !full;
    assign do_pop  = rd_en && not_empty;

    // **************************************************
    // storage
    // **************************************************
    always_ff @(posedge adc_data_clk) begin
        if (do_push)
            mem[wr_ptr] <= wr_entry;
    end

    assign rd_entry = mem[rd_ptr];     // valid in the same cycle as not_empty

    // **************************************************
    // pointers and fill count
    // **************************************************
    always_ff @(posedge adc_data_clk or negedge acq_on) begin
        if (!acq_on) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;   // wraps at FIFO_DEPTH
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;     // none, or push and pop together
            endcase
        end
    end

    assign not_empty   = fill != '0;
    assign free_words  = fifo_level_t'(FIFO_DEPTH) - fill;
    assign almost_full = fill >= fifo_level_t'(FIFO_ALMOST_FULL);

    // credit_tx only pops a shown word, packer only pushes into room it checked
    a_no_pop_empty: assert property (@(posedge adc_data_clk) disable iff (!acq_on)
        rd_en |-> not_empty);
    a_no_push_full: assert property (@(posedge adc_data_clk) disable iff (!acq_on)
        wr_en |-> !full);

endmodule

`default_nettype wire

// File: stream_out/credit_tx.sv
`timescale 1ns/1ps
`default_nettype none

module credit_tx import producer_pkg::*; (
    input  logic        adc_data_clk,
    input  logic        acq_on,
    input  fifo_entry_t rd_entry,
    input  logic        not_empty,
    input  logic        credit_return,  // one pulse per freed receiver slot
    output logic        rd_en,
    output logic        out_valid,
    output fifo_entry_t out_word
);

    credit_t credits;   // words the receiver can still take
    logic    send;

    // a word goes out whenever there is both a credit and data
    assign send  = (credits != '0) && not_empty;
    assign rd_en = send;                // pop the head in the send cycle

    // **************************************************
    // credit counter
    // **************************************************
    always_ff @(posedge adc_data_clk or negedge acq_on) begin
        if (!acq_on) begin
            credits   <= credit_t'(CREDIT_INIT);
            out_valid <= 1'b0;
        end else begin
            out_valid <= send;              // one cycle per word
            case ({send, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;   // send and return cancel
            endcase
        end
    end

    // output register, qualified by out_valid
    always_ff @(posedge adc_data_clk) begin
        if (send)
            out_word <= rd_entry;
    end

    // receiver must not hand back more than it was sent
    a_credit_bound: assert property (@(posedge adc_data_clk) disable iff (!acq_on)
        credits <= credit_t'(CREDIT_INIT));

endmodule

`default_nettype wire

// File: design/xdma_data_producer.sv
`timescale 1ns/1ps
`default_nettype none

module xdma_data_producer import producer_pkg::*; (
    input  logic               adc_data_clk,
    input  logic               acq_on,         // also the async reset
    input  logic               big_endian,
    input  logic [PHASE_W-1:0] adc_phase,
    input  adc_bank_t          adc_a_bank,
    input  adc_bank_t          adc_b_bank,
    input  logic               credit_return,
    output logic               out_valid,
    output fifo_entry_t        out_word,
    output producer_status_t   status
);

    framed_word_t frame;
    fifo_level_t  free_words;
    fifo_entry_t  wr_entry, rd_entry;
    logic         wr_en, rd_en;
    logic         not_empty, almost_full, sample_dropped;

    // **************************************************
    // input, processing, output
    // **************************************************
    adc_sample_framer u_framer (
        .adc_data_clk (adc_data_clk),
        .acq_on       (acq_on),
        .adc_phase    (adc_phase),
        .adc_a_bank   (adc_a_bank),
        .adc_b_bank   (adc_b_bank),
        .frame        (frame)
    );

    word_packer u_packer (
        .adc_data_clk   (adc_data_clk),
        .acq_on         (acq_on),
        .big_endian     (big_endian),
        .frame          (frame),
        .free_words     (free_words),
        .wr_en          (wr_en),
        .wr_entry       (wr_entry),
        .sample_dropped (sample_dropped)
    );

    sample_fifo u_fifo (
        .adc_data_clk (adc_data_clk),
        .acq_on       (acq_on),
        .wr_en        (wr_en),
        .wr_entry     (wr_entry),
        .rd_en        (rd_en),
        .rd_entry     (rd_entry),
        .not_empty    (not_empty),
        .free_words   (free_words),
        .almost_full  (almost_full)
    );

    credit_tx u_credit_tx (
        .adc_data_clk  (adc_data_clk),
        .acq_on        (acq_on),
        .rd_entry      (rd_entry),
        .not_empty     (not_empty),
        .credit_return (credit_return),
        .rd_en         (rd_en),
        .out_valid     (out_valid),
        .out_word      (out_word)
    );

    assign status = '{almost_full:    almost_full,
                      fifo_empty:     !not_empty,     // high out of reset
                      sample_dropped: sample_dropped};

endmodule

`default_nettype wire

// File: test/stream_checker.sv
`timescale 1ns/1ps
`default_nettype none

module stream_checker import producer_pkg::*; (
    input  logic             adc_data_clk,
    input  logic             acq_on,
    input  logic             big_endian,
    input  logic             run_end,
    input  logic             credit_return,
    input  logic             out_valid,
    input  fifo_entry_t      out_word,
    input  producer_status_t status,
    output int               errors,
    output int               words,
    output int               gaps
);

    int            word_idx = 0;     // words since reset
    int            sent = 0;         // credit bookkeeping per run
    int            returned = 0;
    int            run_gaps = 0;
    logic          rst_seen = 1'b0;
    logic          have_prev = 1'b0;
    logic          dropped_q = 1'b0; // sample_dropped one cycle back
    stream_word_t  lo_word;          // first half of the pair
    sample_count_t prev_cnt;

    initial begin
        errors = 0;
        words  = 0;
        gaps   = 0;
    end

    function automatic adc_sample_t chan_sample(input sample_count_t idx, input int ch);
        logic [31:0] v;
        v = idx[31:0] * 32'd2654435 + 32'(ch) * 32'd40503 + 32'd341;
        return v[SAMPLE_W-1:0] ^ v[31:32-SAMPLE_W];
    endfunction

    // **************************************************
    // reference word: sample, six zeros, counter byte
    // **************************************************
    function automatic stream_word_t expected_word(input sample_count_t cnt,
                                                   input logic hi, input logic swap);
        stream_word_t w;
        logic [31:0]  lane;
        int           ch;
        for (int n = 0; n < 4; n++) begin
            ch   = hi ? n + 4 : n;                           // high word has ch 4..7
            lane = {chan_sample(cnt, ch), 6'b000000, cnt[8*ch +: 8]};
            if (swap)
                lane = {lane[7:0], lane[15:8], lane[23:16], lane[31:24]};
            w[32*n +: 32] = lane;
        end
        return w;
    endfunction

    // 32 counter bits carried by one word
    function automatic logic [31:0] counter_half(input stream_word_t w, input logic swap);
        logic [31:0] h;
        for (int n = 0; n < 4; n++)
            h[8*n +: 8] = swap ? w[32*n + 24 +: 8] : w[32*n +: 8];
        return h;
    endfunction

    always @(posedge adc_data_clk) begin
        sample_count_t cnt;
        stream_word_t  exp_lo, exp_hi;
        logic          exp_last;
        if (!acq_on) begin
            if (rst_seen && out_valid !== 1'b0) begin
                errors++;
                $display("[FAIL] out_valid in reset: got %h expected 0", out_valid);
            end
            if (rst_seen && status !== producer_status_t'(3'b010)) begin
                errors++;
                $display("[FAIL] status in reset: got %h expected 2", status);
            end
            rst_seen = 1'b1;
            word_idx = 0;
            sent = 0;
            returned = 0;
            run_gaps = 0;
            have_prev = 1'b0;
            dropped_q = 1'b0;
        end else begin
            rst_seen = 1'b0;
            // a drop needs more than FIFO_DEPTH-2 words held, above the almost-full level
            if (status.sample_dropped && !dropped_q && status.almost_full !== 1'b1) begin
                errors++;
                $display("[FAIL] status.almost_full at first drop: got %h expected 1",
                         status.almost_full);
            end
            dropped_q = status.sample_dropped;
            if (out_valid) begin
                sent++;                                      // only earlier credits count
                if (sent - returned > CREDIT_INIT) begin
                    errors++;
                    $display("credit overrun: %0d words sent, %0d credits returned",
                             sent, returned);
                end
            end
            if (credit_return)
                returned++;
            if (out_valid) begin
                words++;
                exp_last = (word_idx % PKT_WORDS) == PKT_WORDS - 1;
                if (out_word.last !== exp_last) begin
                    errors++;
                    $display("[FAIL] out_word.last word %0d: got %h expected %h",
                             word_idx, out_word.last, exp_last);
                end
                if (word_idx % 2 == 0) begin
                    lo_word = out_word.data;                 // wait for the pair
                end else begin
                    cnt = {counter_half(out_word.data, big_endian),
                           counter_half(lo_word, big_endian)};
                    exp_lo = expected_word(cnt, 1'b0, big_endian);
                    exp_hi = expected_word(cnt, 1'b1, big_endian);
                    if (lo_word !== exp_lo) begin
                        errors++;
                        $display("[FAIL] out_word.data low: got %h expected %h", lo_word, exp_lo);
                    end
                    if (out_word.data !== exp_hi) begin
                        errors++;
                        $display("[FAIL] out_word.data high: got %h expected %h",
                                 out_word.data, exp_hi);
                    end
                    if (have_prev && cnt <= prev_cnt) begin
                        errors++;
                        $display("[FAIL] sample counter: got %h expected above %h", cnt, prev_cnt);
                    end else if (have_prev ? cnt != prev_cnt + 64'd1 : cnt != '0) begin
                        gaps++;                              // dropped samples
                        run_gaps++;
                        if (status.sample_dropped !== 1'b1) begin
                            errors++;
                            $display("[FAIL] status.sample_dropped at gap: got %h expected 1",
                                     status.sample_dropped);
                        end
                    end
                    prev_cnt = cnt;
                    have_prev = 1'b1;
                end
                word_idx++;
            end
            if (run_end && run_gaps == 0) begin
                errors++;
                $display("no sample counter gap seen during the slow credit window");
            end
        end
    end

endmodule

`default_nettype wire

// File: test/tb_xdma_data_producer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_xdma_data_producer import producer_pkg::*; ();

    localparam int CLK_PERIOD  = 4;       // ns
    localparam int PHASES      = 25;      // phase count runs 0..24
    localparam int RUN_SAMPLES = 200;     // sample periods per run
    localparam int SLOW_FIRST  = 60;      // slow credit window, in samples
    localparam int SLOW_LAST   = 139;
    localparam int TIMEOUT_NS  = 2 * RUN_SAMPLES * PHASES * CLK_PERIOD + 10000;

    logic               adc_data_clk = 1'b0;
    logic               acq_on;
    logic               big_endian;
    logic [PHASE_W-1:0] adc_phase;
    adc_bank_t          adc_a_bank, adc_b_bank;
    logic               credit_return = 1'b0;
    logic               out_valid;
    fifo_entry_t        out_word;
    producer_status_t   status;
    logic               run_end;          // tells the checker a run is over
    logic               slow_credit;      // throttles the receiver
    int                 owed = 0;         // words received, not yet credited
    logic [31:0]        lcg_state = 32'd13;
    int                 errors, words, gaps;

    always #(CLK_PERIOD/2) adc_data_clk = ~adc_data_clk;

    xdma_data_producer dut0 (.*);

    stream_checker u_checker (.*);

    // channel value for a given sample index
    function automatic adc_sample_t chan_sample(input sample_count_t idx, input int ch);
        logic [31:0] v;
        v = idx[31:0] * 32'd2654435 + 32'(ch) * 32'd40503 + 32'd341;
        return v[SAMPLE_W-1:0] ^ v[31:32-SAMPLE_W];
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // even channels on bank A, odd channels on bank B
    task automatic drive_banks(input int idx);
        for (int k = 0; k < ADC_BANK_CHANNELS; k++) begin
            adc_a_bank[k] <= chan_sample(64'(idx), 2*k);
            adc_b_bank[k] <= chan_sample(64'(idx), 2*k + 1);
        end
    endtask

    // **************************************************
    // run control
    // **************************************************
    task automatic start_run(input logic be);
        @(posedge adc_data_clk);
        acq_on     <= 1'b0;        // 5 cycles of reset
        big_endian <= be;
        adc_phase  <= '0;
        drive_banks(0);
        repeat (5) @(posedge adc_data_clk);
        acq_on <= 1'b1;
    endtask

    task automatic run_samples();
        for (int s = 0; s < RUN_SAMPLES; s++) begin
            slow_credit <= (s >= SLOW_FIRST) && (s <= SLOW_LAST);
            for (int ph = 0; ph < PHASES; ph++) begin
                @(posedge adc_data_clk);
                adc_phase <= PHASE_W'(ph);
                if (ph == 0)
                    drive_banks(s);    // new sample at phase 0
            end
        end
        @(posedge adc_data_clk);
        adc_phase <= '0;               // parked, no more samples
        slow_credit <= 1'b0;
    endtask

    // wait until every word is out and credited back
    task automatic drain_and_close();
        @(negedge adc_data_clk);
        while (!(status.fifo_empty && !out_valid && owed == 0))
            @(negedge adc_data_clk);   // owed and status settle before the falling edge
        @(posedge adc_data_clk);
        run_end <= 1'b1;
        @(posedge adc_data_clk);
        run_end <= 1'b0;
    endtask

    // receiver side, returns a credit per received word at a random rate
    always @(posedge adc_data_clk) begin
        if (!acq_on) begin
            owed = 0;                  // in-flight words are lost in reset
            credit_return <= 1'b0;
        end else begin
            owed = owed + int'(out_valid);
            lcg_state = lcg_next(lcg_state);
            if (owed > 0 && (slow_credit ? lcg_state[21:16] == 6'd0
                                         : lcg_state[15:14] != 2'b00)) begin
                credit_return <= 1'b1;
                owed = owed - 1;
            end else begin
                credit_return <= 1'b0;
            end
        end
    end

    initial begin
        acq_on      = 1'b0;
        big_endian  = 1'b0;
        adc_phase   = '0;
        adc_a_bank  = '0;
        adc_b_bank  = '0;
        run_end     = 1'b0;
        slow_credit = 1'b0;
        start_run(1'b0);               // little endian pass
        run_samples();
        drain_and_close();
        start_run(1'b1);               // byte swapped pass
        run_samples();
        drain_and_close();
        $display("words checked %0d, counter gaps %0d, errors %0d", words, gaps, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    // watchdog, two runs of sample periods plus margin
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: xdma_data_producer.f
common/producer_pkg.sv
design/adc_sample_framer.sv
design/word_packer.sv
stream_out/sample_fifo.sv
stream_out/credit_tx.sv
design/xdma_data_producer.sv
test/stream_checker.sv
test/tb_xdma_data_producer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_xdma_data_producer \
    -f xdma_data_producer.f \
    -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "sim failed" sim.log; then
    echo "simulation FAILED, see sim.log"
    exit 1
fi
echo "simulation ok"
exit 0
